// ==== src.f ====
logic/sincos_pkg.sv
logic/lookup_if.sv
logic/sincos_ctrl.sv
logic/quarter_cos_rom.sv
logic/sign_restore.sv
logic/sincos_top.sv
dv/tb_clk_gen.sv
dv/sincos_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the sine/cosine testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module sincos_tb -Mdir obj_dir
./obj_dir/Vsincos_tb | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi
grep -q "Test passed" sim.log
echo "simulation clean"

// ==== dv/sincos_tb.sv ====
`timescale 1ns/1ps
/*
 * testbench for the sine/cosine top level
 * reset, edge angles, random angles, latency and back-to-back requests
 */
module sincos_tb;
    import sincos_pkg::*;

    localparam int          PHASE_W   = PHASE_W_DEF;
    localparam int          FULL_TURN = 1 << PHASE_W;
    localparam int          QUARTER   = FULL_TURN / 4;
    localparam int          N_RANDOM  = 200;
    localparam int          N_LATENCY = 4;
    localparam int          N_B2B     = 10;
    localparam int          N_REQ     = 8 + N_RANDOM + N_LATENCY + N_B2B;
    localparam int          TIMEOUT   = 6 * N_REQ + 200;   // cycles
    localparam logic [31:0] SEED      = 32'ha0b4_0537;
    localparam real         PI        = 3.14159265358979323846;

    logic               clk;
    logic               rstn;
    logic               i_en;
    logic [PHASE_W-1:0] i_theta;
    logic               o_en;
    sample_t            o_sin;
    sample_t            o_cos;

    int n_tests  = 0;
    int n_checks = 0;
    int n_errors = 0;
    int cycles   = 0;

    tb_clk_gen u_clk_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    sincos_top #(.PHASE_W(PHASE_W)) u_sincos_top (
        .clk     (clk),
        .rstn    (rstn),
        .i_en    (i_en),
        .i_theta (i_theta),
        .o_en    (o_en),
        .o_sin   (o_sin),
        .o_cos   (o_cos)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Test failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic int cos_ref(input int theta);
        real r;
        int  mag;
        if (theta == QUARTER || theta == 3 * QUARTER) return 0;   // exact zero
        r   = FULL_SCALE * $cos(2.0 * PI * theta / FULL_TURN);
        mag = $rtoi(((r < 0.0) ? -r : r) + 0.5);   // half away from zero
        return (r < 0.0) ? -mag : mag;
    endfunction

    function automatic int sin_ref(input int theta);
        return cos_ref((theta - QUARTER + FULL_TURN) % FULL_TURN);
    endfunction

    task automatic check_value(input string what, input int got, input int exp);
        n_checks++;
        assert (got == exp) else begin
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            n_errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        n_tests++;
        $display("%s: %s, %0d errors", name,
                 (n_errors == err_before) ? "ok" : "FAILED", n_errors - err_before);
    endtask

    // ------------------------------------------------------------
    // request driver, entered and left 0.5 ns after an edge
    // ------------------------------------------------------------
    task automatic run_request(input int theta, output int got_sin, output int got_cos,
                               output int lat);
        i_en    = 1'b1;
        i_theta = PHASE_W'(theta);
        @(posedge clk);          // accepting edge
        #0.5;
        i_en = 1'b0;
        lat  = 0;
        while (!o_en && lat < 16) begin
            @(posedge clk);
            #0.5;
            lat++;
        end
        assert (o_en) else begin
            $display("no result strobe for theta %0d within 16 cycles", theta);
            n_errors++;
        end
        got_sin = int'(o_sin);
        got_cos = int'(o_cos);
        @(posedge clk);
        #0.5;
        check_value("o_en one cycle after result", int'(o_en), 0);
    endtask

    task automatic check_angle(input int theta);
        int s;
        int c;
        int lat;
        run_request(theta, s, c, lat);
        check_value($sformatf("sin(%0d)", theta), s, sin_ref(theta));
        check_value($sformatf("cos(%0d)", theta), c, cos_ref(theta));
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------
    task automatic test_reset();
        int e0;
        e0 = n_errors;
        check_value("o_en after reset", int'(o_en), 0);
        check_value("o_sin after reset", int'(o_sin), 0);
        check_value("o_cos after reset", int'(o_cos), 0);
        report_test("reset", e0);
    endtask

    task automatic test_edges();
        int angles[8];
        int e0;
        angles = '{0, QUARTER, 2 * QUARTER, 3 * QUARTER,
                   1, QUARTER - 1, QUARTER + 1, FULL_TURN - 1};
        e0 = n_errors;
        foreach (angles[i]) check_angle(angles[i]);
        report_test("edge angles", e0);
    endtask

    task automatic test_random();
        int e0;
        e0 = n_errors;
        for (int i = 0; i < N_RANDOM; i++) begin
            check_angle(int'($urandom_range(FULL_TURN - 1, 0)));
        end
        report_test("random angles", e0);
    endtask

    task automatic test_latency();
        int e0;
        int theta;
        int s;
        int c;
        int lat;
        e0 = n_errors;
        for (int i = 0; i < N_LATENCY; i++) begin
            theta = int'($urandom_range(FULL_TURN - 1, 0));
            run_request(theta, s, c, lat);
            check_value($sformatf("latency for theta %0d", theta), lat, 4);
        end
        report_test("latency", e0);
    endtask

    // i_en stays high, a new angle every cycle, accepts every 6th edge
    task automatic test_back_to_back();
        int   hist[$];
        int   e0;
        int   theta;
        logic exp_en;
        e0    = n_errors;
        theta = int'($urandom_range(FULL_TURN - 1, 0));
        hist.push_back(theta);
        i_en    = 1'b1;
        i_theta = PHASE_W'(theta);
        for (int cyc = 0; cyc < 6 * N_B2B; cyc++) begin
            @(posedge clk);
            #0.5;
            if (cyc == 6 * N_B2B - 1) begin
                i_en = 1'b0;
            end else begin
                theta = int'($urandom_range(FULL_TURN - 1, 0));
                hist.push_back(theta);
                i_theta = PHASE_W'(theta);
            end
            exp_en = (cyc % 6 == 4);
            check_value($sformatf("o_en at cycle %0d", cyc), int'(o_en), int'(exp_en));
            if (exp_en) begin
                check_value($sformatf("sin(%0d)", hist[cyc-4]), int'(o_sin), sin_ref(hist[cyc-4]));
                check_value($sformatf("cos(%0d)", hist[cyc-4]), int'(o_cos), cos_ref(hist[cyc-4]));
            end
        end
        report_test("back to back", e0);
    endtask

    initial begin
        i_en    = 1'b0;
        i_theta = '0;
        void'($urandom(SEED));
        @(posedge rstn);
        @(posedge clk);
        #0.5;
        test_reset();
        test_edges();
        test_random();
        test_latency();
        test_back_to_back();
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps
/*
 * testbench clock and reset generator
 */
module tb_clk_gen #(
    parameter real PERIOD     = 4.0,
    parameter int  RST_CYCLES = 2
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;                // release away from the clock edge
        rstn = 1'b1;
    end

endmodule

// ==== logic/sincos_top.sv ====
`timescale 1ns/1ps
/*
 * sine/cosine top level
 * controller, quarter-wave table and sign restore
 */
module sincos_top #(
    parameter int PHASE_W = sincos_pkg::PHASE_W_DEF
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                i_en,
    input  logic [PHASE_W-1:0]  i_theta,   // full turn over 2**PHASE_W
    output logic                o_en,
    output sincos_pkg::sample_t o_sin,     // +-1.0 maps to +-16384
    output sincos_pkg::sample_t o_cos
);

    // ------------------------------------------------------------
    // lookup channels
    // ------------------------------------------------------------
    lookup_if #(.PHASE_W(PHASE_W)) req_if ();
    lookup_if #(.PHASE_W(PHASE_W)) rsp_if ();

    sincos_ctrl #(.PHASE_W(PHASE_W)) u_ctrl (
        .clk     (clk),
        .rstn    (rstn),
        .i_en    (i_en),
        .i_theta (i_theta),
        .req     (req_if.req_src)
    );

    quarter_cos_rom #(.PHASE_W(PHASE_W)) u_rom (
        .clk (clk),
        .req (req_if.req_dst),
        .rsp (rsp_if.rsp_src)
    );

    // result pair 4 cycles after the accepting edge
    sign_restore u_restore (
        .clk   (clk),
        .rstn  (rstn),
        .rsp   (rsp_if.rsp_dst),
        .o_en  (o_en),
        .o_sin (o_sin),
        .o_cos (o_cos)
    );

endmodule

// ==== logic/sign_restore.sv ====
`timescale 1ns/1ps
/*
 * sign and zero restoration of table responses
 * holds the cosine until the sine arrives, then presents both with o_en
 */
module sign_restore (
    input  logic                clk,
    input  logic                rstn,
    lookup_if.rsp_dst           rsp,
    output logic                o_en,
    output sincos_pkg::sample_t o_sin,
    output sincos_pkg::sample_t o_cos
);
    import sincos_pkg::*;

    sample_t mag_s;
    sample_t resp_val;
    sample_t cos_hold;
    logic    cos_rsp;
    logic    sin_rsp;

    assign mag_s   = sample_t'(rsp.mag);   // zero-extended
    assign cos_rsp = rsp.valid && !rsp.is_sin;
    assign sin_rsp = rsp.valid && rsp.is_sin;

    // ------------------------------------------------------------
    // restore sign and zero
    // ------------------------------------------------------------
    always_comb begin
        if (rsp.zero) begin
            resp_val = '0;
        end else if (rsp.neg) begin
            resp_val = -mag_s;
        end else begin
            resp_val = mag_s;
        end
    end

    always_ff @(posedge clk) begin
        if (cos_rsp) cos_hold <= resp_val;
    end

    // ------------------------------------------------------------
    // result registers
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_en  <= 1'b0;
            o_sin <= '0;
            o_cos <= '0;
        end else begin
            o_en <= sin_rsp;   // single-cycle strobe
            if (sin_rsp) begin
                o_sin <= resp_val;
                o_cos <= cos_hold;   // results held until the next pair
            end
        end
    end

    // controller and table must deliver cos then sin back to back
    a_cos_before_sin: assert property (@(posedge clk) disable iff (!rstn)
        sin_rsp |-> $past(cos_rsp));

endmodule

// ==== logic/quarter_cos_rom.sv ====
`timescale 1ns/1ps
/*
 * quarter-wave cosine table built at elaboration
 * registered read, tag and sign flags delayed alongside
 */
module quarter_cos_rom #(
    parameter int PHASE_W = sincos_pkg::PHASE_W_DEF
) (
    input  logic      clk,
    lookup_if.req_dst req,
    lookup_if.rsp_src rsp
);
    import sincos_pkg::*;

    localparam int IDX_W = PHASE_W - 2;
    localparam int DEPTH = 1 << IDX_W;

    typedef logic [MAG_W-1:0] mag_table_t [DEPTH];

    // entry k = round(FULL_SCALE * cos(k * pi / (2 * DEPTH)))
    function automatic mag_table_t build_table();
        mag_table_t tbl;
        real        step;
        step = 3.14159265358979323846 / (2.0 * DEPTH);
        for (int k = 0; k < DEPTH; k++) begin
            tbl[k] = MAG_W'($rtoi(FULL_SCALE * $cos(k * step) + 0.5));
        end
        return tbl;
    endfunction

    localparam mag_table_t COS_TABLE = build_table();

    // ------------------------------------------------------------
    // registered read
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        rsp.mag <= COS_TABLE[req.index];
    end

    // flags ride one cycle behind to line up with the data
    always_ff @(posedge clk) begin
        rsp.valid  <= req.valid;
        rsp.is_sin <= req.is_sin;
        rsp.zero   <= req.zero;
        rsp.neg    <= req.neg;
    end

    // index 0 must come back as exactly +1.0
    a_entry0_full: assert property (@(posedge clk)
        req.valid && (req.index == '0) |=> rsp.mag == MAG_W'(FULL_SCALE));

endmodule

// ==== logic/sincos_ctrl.sv ====
`timescale 1ns/1ps
/*
 * sine/cosine request controller
 * accepts one angle at a time, runs the fixed state sequence
 * and folds the angle into a quarter-wave table request
 */
module sincos_ctrl #(
    parameter int PHASE_W = sincos_pkg::PHASE_W_DEF
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               i_en,
    input  logic [PHASE_W-1:0] i_theta,   // full turn over 2**PHASE_W
    lookup_if.req_src          req
);
    import sincos_pkg::*;

    localparam int IDX_W = PHASE_W - 2;

    localparam logic [PHASE_W-1:0] QUARTER = {2'b01, {IDX_W{1'b0}}};
    localparam logic [PHASE_W-1:0] HALF    = {2'b10, {IDX_W{1'b0}}};

    ctrl_state_t        state;
    logic               accept;

    logic [PHASE_W-1:0] half_cos;   // |angle| within a half turn
    logic [PHASE_W-1:0] half_sin;   // same for angle - quarter turn
    logic [PHASE_W-1:0] half_sel;

    logic [IDX_W-1:0]   idx_next;
    logic               zero_next;
    logic               neg_next;

    // cos is even, so fold the upper half turn back onto 0..HALF
    function automatic logic [PHASE_W-1:0] fold_half(input logic [PHASE_W-1:0] a);
        return (a > HALF) ? -a : a;
    endfunction

    assign accept = (state == ST_IDLE) && i_en;

    // ------------------------------------------------------------
    // state sequence
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:     if (i_en) state <= ST_COS_FOLD;   // busy requests are dropped
                ST_COS_FOLD: state <= ST_SIN_FOLD;
                ST_SIN_FOLD: state <= ST_WAIT_COS;
                ST_WAIT_COS: state <= ST_WAIT_SIN;
                ST_WAIT_SIN: state <= ST_GAP;
                default:     state <= ST_IDLE;
            endcase
        end
    end

    // sin(x) = cos(x - quarter turn)
    always_ff @(posedge clk) begin
        if (accept) begin
            half_cos <= fold_half(i_theta);
            half_sin <= fold_half(i_theta - QUARTER);
        end
    end

    // ------------------------------------------------------------
    // quarter-wave fold
    // ------------------------------------------------------------
    always_comb begin
        half_sel = (state == ST_SIN_FOLD) ? half_sin : half_cos;
        if (half_sel > QUARTER) begin
            // second quadrant, mirror and negate
            idx_next  = -half_sel[IDX_W-1:0];
            zero_next = 1'b0;
            neg_next  = 1'b1;
        end else begin
            idx_next  = half_sel[IDX_W-1:0];
            zero_next = (half_sel == QUARTER);   // table can't hold exact 0
            neg_next  = 1'b0;
        end
    end

    // ------------------------------------------------------------
    // request register
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= (state == ST_COS_FOLD) || (state == ST_SIN_FOLD);
        end
    end

    always_ff @(posedge clk) begin
        req.is_sin <= (state == ST_SIN_FOLD);
        req.index  <= idx_next;
        req.zero   <= zero_next;
        req.neg    <= neg_next;
    end

    // every cosine lookup is followed straight away by its sine lookup
    a_req_pair: assert property (@(posedge clk) disable iff (!rstn)
        req.valid && !req.is_sin |=> req.valid && req.is_sin);

    // sine lookup closes the pair
    a_req_end: assert property (@(posedge clk) disable iff (!rstn)
        req.valid && req.is_sin |=> !req.valid);

endmodule

// ==== logic/lookup_if.sv ====
`timescale 1ns/1ps
/*
 * one quarter-wave table transaction
 * folded request from the controller or table response with its flags
 */
interface lookup_if #(
    parameter int PHASE_W = sincos_pkg::PHASE_W_DEF
);
    import sincos_pkg::*;

    logic               valid;    // one-cycle strobe, no back-pressure
    logic               is_sin;   // 1 for sine, 0 for cosine
    logic [PHASE_W-3:0] index;    // quarter-wave address
    logic [MAG_W-1:0]   mag;      // table magnitude
    logic               zero;     // result forced to 0
    logic               neg;      // result negated

    // controller to table
    modport req_src (output valid, is_sin, index, zero, neg);
    modport req_dst (input  valid, is_sin, index, zero, neg);

    // table to sign restore
    modport rsp_src (output valid, is_sin, mag, zero, neg);
    modport rsp_dst (input  valid, is_sin, mag, zero, neg);

endinterface

// ==== logic/sincos_pkg.sv ====
/*
 * sincos package
 * widths, full-scale value, result word and controller states
 */
package sincos_pkg;

    // ------------------------------------------------------------
    // widths and scale
    // ------------------------------------------------------------
    localparam int PHASE_W_DEF = 12;     // full turn is 0..4095
    localparam int OUT_W       = 16;
    localparam int MAG_W       = 15;     // unsigned table magnitude

    // value of +1.0 in result units
    localparam int FULL_SCALE  = 16384;

    // signed result word, -FULL_SCALE .. +FULL_SCALE
    typedef logic signed [OUT_W-1:0] sample_t;

    // ------------------------------------------------------------
    // controller sequence
    // ------------------------------------------------------------
    // one request at a time, cosine lookup first, then sine
    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_COS_FOLD = 3'd1,   // cosine lookup issued
        ST_SIN_FOLD = 3'd2,   // sine lookup issued
        ST_WAIT_COS = 3'd3,   // cosine read back
        ST_WAIT_SIN = 3'd4,   // sine read back
        ST_GAP      = 3'd5    // dead cycle after result
    } ctrl_state_t;

    // the six states above fill 3 bits with two codes spare

endpackage
